//--- flist.f
src/xw_pkg.sv
src/x_w_if.sv
src/wb_commit_if.sv
src/stage_reg.sv
src/regfile.sv
src/execute_unit.sv
src/writeback_unit.sv
src/exec_wb_top.sv
tb/clk_gen.sv
tb/exec_wb_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the exec_wb testbench with Verilator.
# Exit status is nonzero when the build fails or the testbench stops on $fatal.

cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal \
       -f flist.f \
       --top-module exec_wb_tb \
       -o exec_wb_sim \
  && ./obj_dir/exec_wb_sim \
  || { echo "simulation failed"; exit 1; }

//--- src/exec_wb_top.sv
// --------------------
// exec_wb_top
// issue register, execute, result register, writeback and regfile
// --------------------

`timescale 1ns/1ps

module exec_wb_top #(
  parameter int p_wb_intv_delay = 0
) (
  input  logic              clk,
  input  logic              arst_n,

  // issue port
  input  logic              issue_val,
  output logic              issue_rdy,
  input  xw_pkg::alu_op_e   issue_op,
  input  xw_pkg::reg_addr_t issue_rd,
  input  xw_pkg::reg_addr_t issue_rs1,
  input  xw_pkg::reg_addr_t issue_rs2,
  input  xw_pkg::data_t     issue_imm,
  input  logic              issue_wen,

  // commit port
  output logic              wb_val,
  output logic              wb_wen,
  output xw_pkg::reg_addr_t wb_waddr,
  output xw_pkg::data_t     wb_wdata
);

  import xw_pkg::*;

  issue_msg_t issue_msg;
  issue_msg_t ex_msg;
  logic       ex_val;
  logic       ex_rdy;

  xw_msg_t    res_in_msg;
  xw_msg_t    res_out_msg;
  logic       res_in_val;
  logic       res_in_rdy;

  reg_addr_t  raddr0;
  reg_addr_t  raddr1;
  data_t      rdata0;
  data_t      rdata1;

  x_w_if       xw ();
  wb_commit_if commit ();

  // pack the issue fields
  assign issue_msg.op  = issue_op;
  assign issue_msg.rd  = issue_rd;
  assign issue_msg.rs1 = issue_rs1;
  assign issue_msg.rs2 = issue_rs2;
  assign issue_msg.imm = issue_imm;
  assign issue_msg.wen = issue_wen;

  // --------------------
  // issue to execute
  // --------------------

  stage_reg #(.t_msg(issue_msg_t)) issue_reg_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_val  (issue_val),
    .in_rdy  (issue_rdy),
    .in_msg  (issue_msg),
    .out_val (ex_val),
    .out_rdy (ex_rdy),
    .out_msg (ex_msg)
  );

  execute_unit execute_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_val  (ex_val),
    .in_rdy  (ex_rdy),
    .in_msg  (ex_msg),
    .out_val (res_in_val),
    .out_rdy (res_in_rdy),
    .out_msg (res_in_msg),
    .raddr0  (raddr0),
    .raddr1  (raddr1),
    .rdata0  (rdata0),
    .rdata1  (rdata1),
    .commit  (commit.sb)
  );

  // --------------------
  // result to writeback
  // --------------------

  stage_reg #(.t_msg(xw_msg_t)) result_reg_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_val  (res_in_val),
    .in_rdy  (res_in_rdy),
    .in_msg  (res_in_msg),
    .out_val (xw.val),
    .out_rdy (xw.rdy),
    .out_msg (res_out_msg)
  );

  // unpack onto the channel
  assign xw.waddr = res_out_msg.waddr;
  assign xw.wdata = res_out_msg.wdata;
  assign xw.wen   = res_out_msg.wen;

  writeback_unit #(.p_wb_intv_delay(p_wb_intv_delay)) writeback_i (
    .clk    (clk),
    .arst_n (arst_n),
    .xw     (xw.w),
    .commit (commit.src)
  );

  regfile regfile_i (
    .clk    (clk),
    .arst_n (arst_n),
    .raddr0 (raddr0),
    .raddr1 (raddr1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .commit (commit.rf)
  );

  // commit port mirrors the strobe
  assign wb_val   = commit.val;
  assign wb_wen   = commit.wen;
  assign wb_waddr = commit.waddr;
  assign wb_wdata = commit.wdata;

endmodule

//--- src/execute_unit.sv
// --------------------
// execute_unit
// scoreboard hazard check, operand read and single-cycle alu
// --------------------

`timescale 1ns/1ps

module execute_unit (
  input  logic               clk,
  input  logic               arst_n,

  input  logic               in_val,
  output logic               in_rdy,
  input  xw_pkg::issue_msg_t in_msg,

  output logic               out_val,
  input  logic               out_rdy,
  output xw_pkg::xw_msg_t    out_msg,

  output xw_pkg::reg_addr_t  raddr0,
  output xw_pkg::reg_addr_t  raddr1,
  input  xw_pkg::data_t      rdata0,
  input  xw_pkg::data_t      rdata1,

  wb_commit_if.sb            commit
);

  import xw_pkg::*;

  localparam int n_regs = 2 ** $bits(reg_addr_t);

  // one pending bit per register, bit 0 never set
  logic [n_regs-1:0] pending_q;
  logic [n_regs-1:0] sb_set;
  logic [n_regs-1:0] sb_clr;

  logic  wr_dest;
  logic  uses_rs2;
  logic  rs1_busy;
  logic  rs2_busy;
  logic  rd_busy;
  logic  stall;
  logic  fire;
  data_t alu_res;

  // --------------------
  // hazard check
  // --------------------

  always_comb begin
    // register retiring this cycle
    sb_clr = '0;
    if (commit.val && commit.wen) begin
      sb_clr[commit.waddr] = 1'b1;
    end

    wr_dest  = in_msg.wen && (in_msg.rd != '0);
    uses_rs2 = (in_msg.op != op_addi);

    // a commit this cycle reaches us through the regfile bypass
    rs1_busy = pending_q[in_msg.rs1] && !sb_clr[in_msg.rs1];
    rs2_busy = uses_rs2 && pending_q[in_msg.rs2] && !sb_clr[in_msg.rs2];

    // single pending bit cannot track two writes in flight to one rd
    rd_busy  = wr_dest && pending_q[in_msg.rd] && !sb_clr[in_msg.rd];

    stall    = rs1_busy || rs2_busy || rd_busy;
  end

  assign in_rdy  = out_rdy && !stall;
  assign out_val = in_val && !stall;
  assign fire    = out_val && out_rdy;

  always_comb begin
    sb_set = '0;
    if (fire && wr_dest) begin
      sb_set[in_msg.rd] = 1'b1;
    end
  end

  // set wins over a same-cycle clear
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~sb_clr) | sb_set;
    end
  end

  // --------------------
  // operands and alu
  // --------------------

  assign raddr0 = in_msg.rs1;
  assign raddr1 = in_msg.rs2;

  always_comb begin
    case (in_msg.op)
      op_add:  alu_res = rdata0 + rdata1;
      op_sub:  alu_res = rdata0 - rdata1;
      op_and:  alu_res = rdata0 & rdata1;
      op_or:   alu_res = rdata0 | rdata1;
      op_xor:  alu_res = rdata0 ^ rdata1;
      op_slt:  alu_res = ($signed(rdata0) < $signed(rdata1)) ? data_t'(1) : '0;
      op_addi: alu_res = rdata0 + in_msg.imm;
      default: alu_res = '0;
    endcase
  end

  // writes to x0 go out with wen low
  assign out_msg.waddr = in_msg.rd;
  assign out_msg.wdata = alu_res;
  assign out_msg.wen   = wr_dest;

endmodule

//--- src/regfile.sv
// --------------------
// regfile
// 32 x 32-bit register file, two read ports, one commit write port
// x0 reads zero, same-cycle commit bypasses to the reads
// --------------------

`timescale 1ns/1ps

module regfile (
  input  logic              clk,
  input  logic              arst_n,

  input  xw_pkg::reg_addr_t raddr0,
  input  xw_pkg::reg_addr_t raddr1,
  output xw_pkg::data_t     rdata0,
  output xw_pkg::data_t     rdata1,

  wb_commit_if.rf           commit
);

  import xw_pkg::*;

  // x0 has no storage
  data_t regs_q [1:31];
  logic  wr_en;

  assign wr_en = commit.val && commit.wen && (commit.waddr != '0);

  // --------------------
  // write port
  // --------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[commit.waddr] <= commit.wdata;
    end
  end

  // --------------------
  // read ports
  // --------------------

  always_comb begin
    if (raddr0 == '0) begin
      rdata0 = '0;
    end else if (wr_en && (commit.waddr == raddr0)) begin
      // commit in flight this cycle
      rdata0 = commit.wdata;
    end else begin
      rdata0 = regs_q[raddr0];
    end
  end

  always_comb begin
    if (raddr1 == '0) begin
      rdata1 = '0;
    end else if (wr_en && (commit.waddr == raddr1)) begin
      rdata1 = commit.wdata;
    end else begin
      rdata1 = regs_q[raddr1];
    end
  end

endmodule

//--- src/stage_reg.sv
// --------------------
// stage_reg
// one-entry val/rdy pipeline register for any payload type
// --------------------

`timescale 1ns/1ps

module stage_reg #(
  parameter type t_msg = logic
) (
  input  logic clk,
  input  logic arst_n,

  input  logic in_val,
  output logic in_rdy,
  input  t_msg in_msg,

  output logic out_val,
  input  logic out_rdy,
  output t_msg out_msg
);

  logic full_q;
  logic live_q;
  t_msg msg_q;

  // room when empty or when the held item leaves this cycle
  // closed until the first edge out of reset
  assign in_rdy  = live_q && (!full_q || out_rdy);
  assign out_val = full_q;
  assign out_msg = msg_q;

  // goes high one edge after reset release
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      live_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
    end
  end

  // full flag
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full_q <= 1'b0;
    end else if (in_val && in_rdy) begin
      // refill, possibly while draining
      full_q <= 1'b1;
    end else if (out_rdy) begin
      full_q <= 1'b0;
    end
  end

  // payload, only captured on an accepted input
  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      msg_q <= in_msg;
    end
  end

endmodule

//--- src/wb_commit_if.sv
// --------------------
// wb_commit_if
// one-cycle commit strobe from writeback to register file and scoreboard
// --------------------

`timescale 1ns/1ps

interface wb_commit_if;

  import xw_pkg::*;

  // no back-pressure, val is a single-cycle strobe
  logic      val;
  logic      wen;
  reg_addr_t waddr;
  data_t     wdata;

  // writeback drives
  modport src (output val, output wen, output waddr, output wdata);

  // register file write port
  modport rf (input val, input wen, input waddr, input wdata);

  // scoreboard only needs to know which register retired
  modport sb (input val, input wen, input waddr);

endinterface

//--- src/writeback_unit.sv
// --------------------
// writeback_unit
// takes execute results at a limited rate and strobes the commit
// --------------------

`timescale 1ns/1ps

module writeback_unit #(
  parameter int p_wb_intv_delay = 0
) (
  input  logic     clk,
  input  logic     arst_n,

  x_w_if.w         xw,
  wb_commit_if.src commit
);

  // counter wide enough for the delay, at least one bit
  localparam int cnt_w = (p_wb_intv_delay > 0) ? $clog2(p_wb_intv_delay + 1) : 1;

  logic [cnt_w-1:0] intv_cnt_q;
  logic             xfer;

  // --------------------
  // interval throttle
  // --------------------

  assign xw.rdy = (intv_cnt_q == '0);
  assign xfer   = xw.val && xw.rdy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      intv_cnt_q <= '0;
    end else if (xfer) begin
      // idle cycles after every accepted result
      intv_cnt_q <= cnt_w'(p_wb_intv_delay);
    end else if (intv_cnt_q != '0) begin
      intv_cnt_q <= intv_cnt_q - 1'b1;
    end
  end

  // --------------------
  // commit strobe
  // --------------------

  // same cycle as the accept
  assign commit.val   = xfer;
  assign commit.wen   = xw.wen;
  assign commit.waddr = xw.waddr;
  assign commit.wdata = xw.wdata;

endmodule

//--- src/x_w_if.sv
// --------------------
// x_w_if
// execute-to-writeback result channel with val/rdy handshake
// --------------------

`timescale 1ns/1ps

interface x_w_if;

  import xw_pkg::*;

  // handshake
  logic      val;
  logic      rdy;

  // result payload, stable while val waits for rdy
  reg_addr_t waddr;
  data_t     wdata;
  logic      wen;

  // execute side
  modport x (output val, output waddr, output wdata, output wen, input rdy);

  // writeback side
  modport w (input val, input waddr, input wdata, input wen, output rdy);

endinterface

//--- src/xw_pkg.sv
// --------------------
// xw_pkg
// shared widths, alu operations and the message structs of the
// execute-to-writeback slice
// --------------------

package xw_pkg;

  // datapath width, fixed for the whole slice
  localparam int data_w = 32;

  typedef logic [data_w-1:0] data_t;

  // 32 architectural registers
  typedef logic [4:0] reg_addr_t;

  // --------------------
  // alu operations
  // --------------------

  typedef enum logic [2:0] {
    op_add  = 3'd0,
    op_sub  = 3'd1,
    op_and  = 3'd2,
    op_or   = 3'd3,
    op_xor  = 3'd4,
    // signed compare, result is 1 or 0
    op_slt  = 3'd5,
    // rs1 plus immediate, rs2 not read
    op_addi = 3'd6
  } alu_op_e;

  // --------------------
  // messages
  // --------------------

  // instruction as issued into the slice
  typedef struct packed {
    alu_op_e   op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     imm;
    logic      wen;
  } issue_msg_t;

  // execute result on its way to writeback
  typedef struct packed {
    reg_addr_t waddr;
    data_t     wdata;
    logic      wen;
  } xw_msg_t;

endpackage

//--- tb/clk_gen.sv
// --------------------
// clk_gen
// testbench clock, 10 ns period, reset low for three cycles
// --------------------

`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // release on a falling edge, clear of the flops
  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

//--- tb/exec_wb_tb.sv
// --------------------
// exec_wb_tb
// directed tests for the execute-to-writeback slice, checked against
// a register model that predicts every commit in issue order
// --------------------

`timescale 1ns/1ps

module exec_wb_tb;

  import xw_pkg::*;

  logic      clk;
  logic      arst_n;
  logic      issue_val;
  logic      issue_rdy;
  alu_op_e   issue_op;
  reg_addr_t issue_rd;
  reg_addr_t issue_rs1;
  reg_addr_t issue_rs2;
  data_t     issue_imm;
  logic      issue_wen;
  logic      wb_val;
  logic      wb_wen;
  reg_addr_t wb_waddr;
  data_t     wb_wdata;

  // reference state
  data_t     model_regs [32];
  xw_msg_t   exp_q [$];
  logic [15:0] lfsr_q;

  clk_gen clk_gen_i (
    .clk    (clk),
    .arst_n (arst_n)
  );

  exec_wb_top #(.p_wb_intv_delay(2)) dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .issue_val (issue_val),
    .issue_rdy (issue_rdy),
    .issue_op  (issue_op),
    .issue_rd  (issue_rd),
    .issue_rs1 (issue_rs1),
    .issue_rs2 (issue_rs2),
    .issue_imm (issue_imm),
    .issue_wen (issue_wen),
    .wb_val    (wb_val),
    .wb_wen    (wb_wen),
    .wb_waddr  (wb_waddr),
    .wb_wdata  (wb_wdata)
  );

  // --------------------
  // failure and compare
  // --------------------

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic give_up(input string what);
    $display("%s at %0t ns", what, $time);
    abort_run();
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
      $display("FAIL at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // --------------------
  // model and stimulus
  // --------------------

  // fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic data_t ref_alu(input alu_op_e op, input data_t a, input data_t b,
                                    input data_t imm);
    data_t res;
    res = '0;
    if (op == op_add) res = a + b;
    else if (op == op_sub) res = a + ~b + 32'd1;
    else if (op == op_and) res = a & b;
    else if (op == op_or) res = a | b;
    else if (op == op_xor) res = a ^ b;
    else if (op == op_addi) res = a + imm;
    else if (op == op_slt) begin
      // differing signs decide by a's sign bit
      if (a[31] != b[31]) res = {31'd0, a[31]};
      else res = {31'd0, (a < b)};
    end
    return res;
  endfunction

  // called on the edge where the issue transfer happened
  task automatic model_issue(input alu_op_e op, input reg_addr_t rd, input reg_addr_t rs1,
                             input reg_addr_t rs2, input data_t imm, input logic wen);
    xw_msg_t exp;
    exp.waddr = rd;
    exp.wdata = ref_alu(op, model_regs[rs1], model_regs[rs2], imm);
    exp.wen   = wen && (rd != 5'd0);
    exp_q.push_back(exp);
    if (exp.wen) model_regs[rd] = exp.wdata;
  endtask

  // enter and leave on a rising edge
  task automatic issue_instr(input alu_op_e op, input reg_addr_t rd, input reg_addr_t rs1,
                             input reg_addr_t rs2, input data_t imm, input logic wen);
    int waited;
    issue_val <= 1'b1;
    issue_op  <= op;
    issue_rd  <= rd;
    issue_rs1 <= rs1;
    issue_rs2 <= rs2;
    issue_imm <= imm;
    issue_wen <= wen;
    waited = 0;
    @(negedge clk);
    while (!issue_rdy) begin
      waited++;
      if (waited > 50) give_up("issue port stayed busy");
      @(negedge clk);
    end
    @(posedge clk);
    model_issue(op, rd, rs1, rs2, imm, wen);
  endtask

  task automatic release_issue();
    issue_val <= 1'b0;
  endtask

  // all predicted commits seen
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > 200) give_up("outstanding instructions never committed");
    end
    repeat (4) @(posedge clk);
  endtask

  // --------------------
  // commit monitor
  // --------------------

  always @(negedge clk) begin : commit_monitor
    xw_msg_t exp;
    if (!arst_n) begin
      check_bit("wb_val", 1'b0, wb_val);
      check_bit("issue_rdy", 1'b0, issue_rdy);
    end else if (wb_val) begin
      if (exp_q.size() == 0) begin
        give_up("commit seen with no instruction outstanding");
      end else begin
        exp = exp_q.pop_front();
        check_bit("wb_wen", exp.wen, wb_wen);
        check_addr("wb_waddr", exp.waddr, wb_waddr);
        check_data("wb_wdata", exp.wdata, wb_wdata);
      end
    end
  end

  // --------------------
  // tests
  // --------------------

  task automatic test_reset_idle();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!issue_rdy) begin
      waited++;
      if (waited > 20) give_up("issue_rdy never rose after reset");
      @(negedge clk);
    end
    // monitor flags any commit here
    repeat (6) @(posedge clk);
  endtask

  task automatic test_alu_ops();
    issue_instr(op_addi, 5'd1, 5'd0, 5'd0, 32'd100, 1'b1);
    issue_instr(op_addi, 5'd2, 5'd0, 5'd0, 32'hffff_fff9, 1'b1);
    issue_instr(op_addi, 5'd3, 5'd0, 5'd0, 32'h0f0f_1234, 1'b1);
    issue_instr(op_add, 5'd4, 5'd1, 5'd2, 32'd0, 1'b1);
    issue_instr(op_sub, 5'd5, 5'd1, 5'd2, 32'd0, 1'b1);
    issue_instr(op_and, 5'd6, 5'd1, 5'd3, 32'd0, 1'b1);
    issue_instr(op_or, 5'd7, 5'd2, 5'd3, 32'd0, 1'b1);
    issue_instr(op_xor, 5'd8, 5'd2, 5'd3, 32'd0, 1'b1);
    // signed: -7 < 100 but not the reverse
    issue_instr(op_slt, 5'd9, 5'd2, 5'd1, 32'd0, 1'b1);
    issue_instr(op_slt, 5'd10, 5'd1, 5'd2, 32'd0, 1'b1);
    release_issue();
    wait_drain();
  endtask

  task automatic test_x0_write();
    issue_instr(op_addi, 5'd0, 5'd1, 5'd0, 32'd5, 1'b1);
    issue_instr(op_add, 5'd11, 5'd0, 5'd1, 32'd0, 1'b1);
    issue_instr(op_or, 5'd12, 5'd0, 5'd0, 32'd0, 1'b1);
    release_issue();
    wait_drain();
  endtask

  task automatic test_dependent_chain();
    issue_instr(op_addi, 5'd13, 5'd0, 5'd0, 32'd1, 1'b1);
    issue_instr(op_addi, 5'd14, 5'd13, 5'd0, 32'd3, 1'b1);
    issue_instr(op_add, 5'd15, 5'd14, 5'd14, 32'd0, 1'b1);
    issue_instr(op_sub, 5'd16, 5'd15, 5'd13, 32'd0, 1'b1);
    issue_instr(op_xor, 5'd17, 5'd16, 5'd15, 32'd0, 1'b1);
    release_issue();
    wait_drain();
  endtask

  task automatic test_no_write_enable();
    issue_instr(op_addi, 5'd1, 5'd0, 5'd0, 32'd999, 1'b0);
    // x1 must still hold 100
    issue_instr(op_add, 5'd18, 5'd1, 5'd0, 32'd0, 1'b1);
    release_issue();
    wait_drain();
  endtask

  task automatic test_random_stream();
    logic [31:0] r;
    alu_op_e     op;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    data_t       imm;
    logic        wen;
    for (int k = 0; k < 40; k++) begin
      r   = rand_bits(3);
      // code 7 is unused, fold onto addi
      op  = (r[2:0] == 3'd7) ? op_addi : alu_op_e'(r[2:0]);
      rd  = reg_addr_t'(rand_bits(5));
      rs1 = reg_addr_t'(rand_bits(5));
      rs2 = reg_addr_t'(rand_bits(5));
      r   = rand_bits(12);
      imm = {{20{r[11]}}, r[11:0]};
      wen = (rand_bits(2) != 32'd0);
      issue_instr(op, rd, rs1, rs2, imm, wen);
    end
    release_issue();
    wait_drain();
  endtask

  // --------------------
  // sequence
  // --------------------

  initial begin : main
    int waited;
    issue_val <= 1'b0;
    issue_op  <= op_add;
    issue_rd  <= '0;
    issue_rs1 <= '0;
    issue_rs2 <= '0;
    issue_imm <= '0;
    issue_wen <= 1'b0;
    lfsr_q    = 16'd27;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    waited = 0;
    while (!arst_n) begin
      @(posedge clk);
      waited++;
      if (waited > 20) give_up("reset never released");
    end
    @(posedge clk);
    test_reset_idle();
    test_alu_ops();
    test_x0_write();
    test_dependent_chain();
    test_no_write_enable();
    test_random_stream();
    $display("Test OK");
    $finish;
  end

endmodule
